/* logic/apbDecode.sv */
`timescale 1ns/1ps

module apbDecode import periphPkg::*; (
	input logic clk,
	input logic rst,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input apbAddr paddr,
	output logic segWr,
	output logic ledWr,
	output logic ctrlWr,
	output logic rdLoad,
	output regIndex rdIndex,
	output logic pready,
	output logic pslverr
);

	decodeState state;
	decodeState stateNext;
	regIndex index;
	logic access;
	logic accessWr;
	logic accessRd;
	logic invalidIdx;
	logic readOnlyIdx;

	// Word index from the byte address
	assign index = paddr[7:2];
	assign rdIndex = index;

	//////////////////////////////
	// Access classification
	//////////////////////////////

	// First access cycle only, READWAIT blocks a second load
	assign access = psel && penable;
	assign accessWr = access && pwrite && (state == IDLE);
	assign accessRd = access && !pwrite && (state == IDLE);

	assign invalidIdx = index > IDX_SEGCTRL;
	assign readOnlyIdx = (index == IDX_SWITCH) || (index == IDX_BUTTON);

	// One-cycle write pulses to the registers
	assign segWr = accessWr && (index == IDX_SEG);
	assign ledWr = accessWr && (index == IDX_LED);
	assign ctrlWr = accessWr && (index == IDX_SEGCTRL);

	// Read data is captured at the end of the first access cycle
	assign rdLoad = accessRd;

	//////////////////////////////
	// Phase FSM
	//////////////////////////////

	always_comb
	begin
		stateNext = state;
		case (state)
			IDLE:
				if (accessRd)
					stateNext = READWAIT;
			READWAIT:
				stateNext = IDLE;
			default:
				stateNext = IDLE;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			state <= IDLE;
		else
			state <= stateNext;
	end

	// Writes finish at once, reads after the wait state
	assign pready = accessWr || (state == READWAIT);
	assign pslverr = pready && (invalidIdx || (pwrite && readOnlyIdx));

	// Master side of the protocol
	penableNeedsPsel: assert property (@(posedge clk) disable iff (rst)
		penable |-> psel);

	// A response needs the master to still be in its access phase
	readyInAccess: assert property (@(posedge clk) disable iff (rst)
		pready |-> (psel && penable));

endmodule

/* logic/gpioReg.sv */
`timescale 1ns/1ps

module gpioReg import periphPkg::*; (
	input logic clk,
	input logic rst,
	input logic wr,
	input regWord din,
	input byteStrobe strb,
	output regWord q
);

	//////////////////////////////
	// Byte-lane register
	//////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			q <= '0;
		end
		else if (wr)
		begin
			// Only lanes with a strobe bit set change
			for (int lane = 0; lane < 4; lane++)
			begin
				if (strb[lane])
					q[lane*8 +: 8] <= din[lane*8 +: 8];
			end
		end
	end

endmodule

/* logic/inputDebounce.sv */
`timescale 1ns/1ps

module inputDebounce #(
	parameter int WIDTH = 16,
	parameter int SAMPLE_DIV = 50000,
	parameter int FILTER_LEN = 4
)(
	input logic clk,
	input logic rst,
	input logic [WIDTH-1:0] raw,
	output logic [WIDTH-1:0] clean
);

	localparam int DIV_W = $clog2(SAMPLE_DIV + 1);
	localparam int CNT_W = $clog2(FILTER_LEN + 1);

	logic [WIDTH-1:0] syncA;
	logic [WIDTH-1:0] syncB;
	logic [DIV_W-1:0] divCnt;
	logic sampleTick;
	logic [CNT_W-1:0] runCnt [WIDTH];

	// Two-flop synchronizer per input bit
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			syncA <= '0;
			syncB <= '0;
		end
		else
		begin
			syncA <= raw;
			syncB <= syncA;
		end
	end

	//////////////////////////////
	// Sample tick
	//////////////////////////////

	assign sampleTick = (divCnt == DIV_W'(SAMPLE_DIV - 1));

	always_ff @(posedge clk)
	begin
		if (rst || sampleTick)
			divCnt <= '0;
		else
			divCnt <= divCnt + 1'b1;
	end

	//////////////////////////////
	// Stability filter
	//////////////////////////////

	// Counts samples in a row that differ from clean
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			clean <= '0;
			for (int i = 0; i < WIDTH; i++)
				runCnt[i] <= '0;
		end
		else if (sampleTick)
		begin
			for (int i = 0; i < WIDTH; i++)
			begin
				if (syncB[i] == clean[i])
				begin
					runCnt[i] <= '0;
				end
				else if (runCnt[i] == CNT_W'(FILTER_LEN - 1))
				begin
					clean[i] <= syncB[i];
					runCnt[i] <= '0;
				end
				else
				begin
					runCnt[i] <= runCnt[i] + 1'b1;
				end
			end
		end
	end

endmodule

/* logic/periphPkg.sv */
package periphPkg;

	//////////////////////////////
	// Bus and register widths
	//////////////////////////////

	// Byte address on the APB port
	typedef logic [7:0] apbAddr;

	// One register word
	typedef logic [31:0] regWord;

	// Byte lanes of a write, same as pstrb
	typedef logic [3:0] byteStrobe;

	// Word index, address bits 7 to 2
	typedef logic [5:0] regIndex;

	//////////////////////////////
	// Register map
	//////////////////////////////

	// Read-only inputs
	localparam regIndex IDX_SWITCH = 6'd0;
	localparam regIndex IDX_BUTTON = 6'd1;

	// Writable registers
	localparam regIndex IDX_SEG = 6'd2;
	localparam regIndex IDX_LED = 6'd3;
	localparam regIndex IDX_SEGCTRL = 6'd4;

	//////////////////////////////
	// Decode FSM
	//////////////////////////////

	// READWAIT is the single wait state of a read
	typedef enum logic {
		IDLE,
		READWAIT
	} decodeState;

endpackage

/* logic/periphTop.sv */
`timescale 1ns/1ps

module periphTop import periphPkg::*; #(
	parameter int SW_WIDTH = 16,
	parameter int BTN_WIDTH = 5,
	parameter int SAMPLE_DIV = 50000,
	parameter int FILTER_LEN = 4,
	parameter int SCAN_DIV = 100000,
	parameter int BLINK_DIV = 25
)(
	input logic clk,
	input logic rst,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input apbAddr paddr,
	input regWord pwdata,
	input byteStrobe pstrb,
	input logic [SW_WIDTH-1:0] sw,
	input logic [BTN_WIDTH-1:0] btn,
	output regWord prdata,
	output logic pready,
	output logic pslverr,
	output logic [15:0] led,
	output logic [7:0] segment,
	output logic [7:0] anode
);

	logic segWr;
	logic ledWr;
	logic ctrlWr;
	logic rdLoad;
	regIndex rdIndex;
	regWord segQ;
	regWord ledQ;
	regWord ctrlQ;
	logic [SW_WIDTH-1:0] swClean;
	logic [BTN_WIDTH-1:0] btnClean;

	//////////////////////////////
	// Decode stage
	//////////////////////////////

	apbDecode decode_i (.clk(clk), .rst(rst), .psel(psel), .penable(penable),
		.pwrite(pwrite), .paddr(paddr), .segWr(segWr), .ledWr(ledWr), .ctrlWr(ctrlWr),
		.rdLoad(rdLoad), .rdIndex(rdIndex), .pready(pready), .pslverr(pslverr));

	//////////////////////////////
	// Execute blocks
	//////////////////////////////

	gpioReg segReg (.clk(clk), .rst(rst), .wr(segWr), .din(pwdata), .strb(pstrb),
		.q(segQ));
	gpioReg ledReg (.clk(clk), .rst(rst), .wr(ledWr), .din(pwdata), .strb(pstrb),
		.q(ledQ));
	gpioReg ctrlReg (.clk(clk), .rst(rst), .wr(ctrlWr), .din(pwdata), .strb(pstrb),
		.q(ctrlQ));

	// Board LEDs show the low half only
	assign led = ledQ[15:0];

	inputDebounce #(.WIDTH(SW_WIDTH), .SAMPLE_DIV(SAMPLE_DIV), .FILTER_LEN(FILTER_LEN))
		swFilter (.clk(clk), .rst(rst), .raw(sw), .clean(swClean));
	inputDebounce #(.WIDTH(BTN_WIDTH), .SAMPLE_DIV(SAMPLE_DIV), .FILTER_LEN(FILTER_LEN))
		btnFilter (.clk(clk), .rst(rst), .raw(btn), .clean(btnClean));

	segScan #(.SCAN_DIV(SCAN_DIV), .BLINK_DIV(BLINK_DIV)) scan_i (.clk(clk), .rst(rst),
		.data(segQ), .ctrl(ctrlQ), .segment(segment), .anode(anode));

	//////////////////////////////
	// Result stage
	//////////////////////////////

	readMux #(.SW_WIDTH(SW_WIDTH), .BTN_WIDTH(BTN_WIDTH)) mux_i (.clk(clk), .rst(rst),
		.rdLoad(rdLoad), .rdIndex(rdIndex), .switches(swClean), .buttons(btnClean),
		.seg(segQ), .led(ledQ), .segCtrl(ctrlQ), .prdata(prdata));

endmodule

/* logic/readMux.sv */
`timescale 1ns/1ps

module readMux import periphPkg::*; #(
	parameter int SW_WIDTH = 16,
	parameter int BTN_WIDTH = 5
)(
	input logic clk,
	input logic rst,
	input logic rdLoad,
	input regIndex rdIndex,
	input logic [SW_WIDTH-1:0] switches,
	input logic [BTN_WIDTH-1:0] buttons,
	input regWord seg,
	input regWord led,
	input regWord segCtrl,
	output regWord prdata
);

	regWord selWord;

	//////////////////////////////
	// Word select
	//////////////////////////////

	// Input banks are zero-extended to a full word
	always_comb
	begin
		case (rdIndex)
			IDX_SWITCH: selWord = regWord'(switches);
			IDX_BUTTON: selWord = regWord'(buttons);
			IDX_SEG: selWord = seg;
			IDX_LED: selWord = led;
			IDX_SEGCTRL: selWord = segCtrl;
			// Unmapped words read as zero
			default: selWord = '0;
		endcase
	end

	//////////////////////////////
	// Read data register
	//////////////////////////////

	// Holds between loads so prdata is stable in the ready cycle
	always_ff @(posedge clk)
	begin
		if (rst)
			prdata <= '0;
		else if (rdLoad)
			prdata <= selWord;
	end

endmodule

/* logic/segScan.sv */
`timescale 1ns/1ps

module segScan import periphPkg::*; #(
	parameter int SCAN_DIV = 100000,
	parameter int BLINK_DIV = 25
)(
	input logic clk,
	input logic rst,
	input regWord data,
	input regWord ctrl,
	output logic [7:0] segment,
	output logic [7:0] anode
);

	localparam int SCAN_W = $clog2(SCAN_DIV + 1);

	logic [SCAN_W-1:0] scanCnt;
	logic [2:0] digit;
	logic [BLINK_DIV-1:0] blinkCnt;
	logic [3:0] nibble;
	logic [6:0] hexSeg;
	logic blankAll;

	//////////////////////////////
	// Digit pointer and blink
	//////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			scanCnt <= '0;
			digit <= '0;
		end
		else if (scanCnt == SCAN_W'(SCAN_DIV - 1))
		begin
			scanCnt <= '0;
			// Wraps from 7 back to 0
			digit <= digit + 1'b1;
		end
		else
		begin
			scanCnt <= scanCnt + 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			blinkCnt <= '0;
		else
			blinkCnt <= blinkCnt + 1'b1;
	end

	// Upper half of the blink period is the off half
	assign blankAll = ctrl[16] && blinkCnt[BLINK_DIV-1];

	//////////////////////////////
	// Hex decode, active low gfedcba
	//////////////////////////////

	assign nibble = data[digit*4 +: 4];

	always_comb
	begin
		case (nibble)
			4'h0: hexSeg = 7'h40;
			4'h1: hexSeg = 7'h79;
			4'h2: hexSeg = 7'h24;
			4'h3: hexSeg = 7'h30;
			4'h4: hexSeg = 7'h19;
			4'h5: hexSeg = 7'h12;
			4'h6: hexSeg = 7'h02;
			4'h7: hexSeg = 7'h78;
			4'h8: hexSeg = 7'h00;
			4'h9: hexSeg = 7'h10;
			4'hA: hexSeg = 7'h08;
			4'hB: hexSeg = 7'h03;
			4'hC: hexSeg = 7'h46;
			4'hD: hexSeg = 7'h21;
			4'hE: hexSeg = 7'h06;
			default: hexSeg = 7'h0E;
		endcase
	end

	// Outputs registered so segment and anode switch together
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			anode <= 8'hFF;
			segment <= 8'hFF;
		end
		else
		begin
			anode <= 8'hFF;
			if (ctrl[digit] && !blankAll)
				anode[digit] <= 1'b0;
			segment <= {~ctrl[8 + digit], hexSeg};
		end
	end

	// Never two digits lit at once
	oneDigitLit: assert property (@(posedge clk) disable iff (rst)
		$onehot0(~anode));

endmodule

/* sim.f */
logic/periphPkg.sv
logic/apbDecode.sv
logic/gpioReg.sv
logic/inputDebounce.sv
logic/segScan.sv
logic/readMux.sv
logic/periphTop.sv
tb/periphChecks.sv
tb/periphTb.sv

/* tb/periphChecks.sv */
`timescale 1ns/1ps

module periphChecks import periphPkg::*; (
	input logic clk,
	input logic rst,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input regWord prdata,
	input logic pready,
	input logic pslverr,
	input logic [15:0] led,
	input logic [7:0] segment,
	input logic [7:0] anode,
	input regWord expRead,
	input logic expErr,
	input regWord segModel,
	input regWord ledModel,
	input regWord ctrlModel,
	output int dataErrors,
	output int protoErrors,
	output int scanErrors
);

	// Active low gfedcba patterns for 0 to F
	localparam logic [6:0] HEX_TABLE [16] = '{
		7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
		7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E
	};

	initial
	begin
		dataErrors = 0;
		protoErrors = 0;
		scanErrors = 0;
	end

	// Lit digit must be enabled, alone, and show its nibble and point
	function automatic logic digitOk(input logic [7:0] an, input logic [7:0] seg,
		input regWord data, input regWord ctrl);
		int k;
		k = 0;
		for (int i = 0; i < 8; i++)
		begin
			if (!an[i])
				k = i;
		end
		return $onehot(~an) && ctrl[k] && (seg == {~ctrl[8 + k], HEX_TABLE[data[k*4 +: 4]]});
	endfunction

	//////////////////////////////
	// Read data and LEDs
	//////////////////////////////

	readResult: assert property (@(posedge clk) disable iff (rst)
		(psel && penable && pready && !pwrite) |-> (prdata == expRead && pslverr == expErr))
	else
	begin
		dataErrors++;
		$display("error at %0t: read gave %h err %b, expected %h err %b", $time,
			$sampled(prdata), $sampled(pslverr), $sampled(expRead), $sampled(expErr));
	end

	ledPins: assert property (@(posedge clk) disable iff (rst) led == ledModel[15:0])
	else
	begin
		dataErrors++;
		$display("error at %0t: led pins %h, expected %h", $time, $sampled(led),
			$sampled(ledModel[15:0]));
	end

	//////////////////////////////
	// Handshake timing
	//////////////////////////////

	// Exactly one wait state on a read
	readWait: assert property (@(posedge clk) disable iff (rst)
		(psel && !penable && !pwrite) |=> (!pready ##1 pready))
	else
	begin
		protoErrors++;
		$display("error at %0t: read pready not one cycle into the access phase", $time);
	end

	writeNoWait: assert property (@(posedge clk) disable iff (rst)
		(psel && !penable && pwrite) |=> pready)
	else
	begin
		protoErrors++;
		$display("error at %0t: write pready missing in first access cycle", $time);
	end

	writeResult: assert property (@(posedge clk) disable iff (rst)
		(psel && penable && pready && pwrite) |-> (pslverr == expErr))
	else
	begin
		protoErrors++;
		$display("error at %0t: write pslverr %b, expected %b", $time, $sampled(pslverr),
			$sampled(expErr));
	end

	// Checked in and just after reset
	resetQuiet: assert property (@(posedge clk)
		rst |=> (!pready && !pslverr && led == '0 && anode == 8'hFF))
	else
	begin
		protoErrors++;
		$display("error at %0t: outputs not idle during reset", $time);
	end

	//////////////////////////////
	// Display scan
	//////////////////////////////

	// Outputs lag the registers by one cycle, so skip cycles right after a write
	scanDigit: assert property (@(posedge clk) disable iff (rst)
		(anode != 8'hFF && $stable(segModel) && $stable(ctrlModel) && !ctrlModel[16])
		|-> digitOk(anode, segment, segModel, ctrlModel))
	else
	begin
		scanErrors++;
		$display("error at %0t: anode %b segment %h with data %h ctrl %h", $time,
			$sampled(anode), $sampled(segment), $sampled(segModel), $sampled(ctrlModel));
	end

endmodule

/* tb/periphTb.sv */
`timescale 1ns/1ps

module periphTb import periphPkg::*; ();

	localparam int SAMPLE_DIV = 4;
	localparam int FILTER_LEN = 4;
	localparam int SCAN_DIV = 8;
	localparam int BLINK_DIV = 10;
	localparam int SETTLE_CYCLES = SAMPLE_DIV * (FILTER_LEN + 3);
	localparam int TIMEOUT_CYCLES = 20000;

	logic clk;
	logic rst;
	logic psel;
	logic penable;
	logic pwrite;
	apbAddr paddr;
	regWord pwdata;
	byteStrobe pstrb;
	logic [15:0] sw;
	logic [4:0] btn;
	regWord prdata;
	logic pready;
	logic pslverr;
	logic [15:0] led;
	logic [7:0] segment;
	logic [7:0] anode;
	regWord expRead;
	logic expErr;
	regWord regModel [5];
	int cycles = 0;
	int dataErrors;
	int protoErrors;
	int scanErrors;

	periphTop #(.SW_WIDTH(16), .BTN_WIDTH(5), .SAMPLE_DIV(SAMPLE_DIV),
		.FILTER_LEN(FILTER_LEN), .SCAN_DIV(SCAN_DIV), .BLINK_DIV(BLINK_DIV)) dut_i (
		.clk(clk), .rst(rst), .psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .pstrb(pstrb), .sw(sw), .btn(btn),
		.prdata(prdata), .pready(pready), .pslverr(pslverr), .led(led),
		.segment(segment), .anode(anode));

	periphChecks checks_i (.clk(clk), .rst(rst), .psel(psel), .penable(penable),
		.pwrite(pwrite), .prdata(prdata), .pready(pready), .pslverr(pslverr), .led(led),
		.segment(segment), .anode(anode), .expRead(expRead), .expErr(expErr),
		.segModel(regModel[IDX_SEG]), .ledModel(regModel[IDX_LED]),
		.ctrlModel(regModel[IDX_SEGCTRL]), .dataErrors(dataErrors),
		.protoErrors(protoErrors), .scanErrors(scanErrors));

	always #10 clk = ~clk;

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES)
		begin
			$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	//////////////////////////////
	// APB master
	//////////////////////////////

	// Returns on the edge that completes the transfer
	task automatic waitReady();
		do
			@(negedge clk);
		while (!pready);
		@(posedge clk);
	endtask

	task automatic apbAccess(input logic wr, input apbAddr addr, input regWord data,
		input byteStrobe strb, input regWord expected, input logic err);
		@(posedge clk);
		psel <= 1'b1;
		pwrite <= wr;
		paddr <= addr;
		pwdata <= data;
		pstrb <= strb;
		expRead <= expected;
		expErr <= err;
		@(posedge clk);
		penable <= 1'b1;
		waitReady();
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	function automatic regWord mergeLanes(input regWord old, input regWord data,
		input byteStrobe strb);
		regWord result;
		result = old;
		for (int lane = 0; lane < 4; lane++)
		begin
			if (strb[lane])
				result[lane*8 +: 8] = data[lane*8 +: 8];
		end
		return result;
	endfunction

	task automatic writeReg(input regIndex idx, input regWord data, input byteStrobe strb);
		apbAccess(1'b1, {idx, 2'b00}, data, strb, '0, 1'b0);
		regModel[idx] = mergeLanes(regModel[idx], data, strb);
	endtask

	task automatic readReg(input regIndex idx);
		apbAccess(1'b0, {idx, 2'b00}, '0, '0, regModel[idx], 1'b0);
	endtask

	//////////////////////////////
	// Test sequence
	//////////////////////////////

	initial
	begin
		regIndex idx;
		logic [15:0] swHeld;
		logic [4:0] btnHeld;
		int total;
		void'($urandom(73150));
		clk = 1'b0;
		rst = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		pstrb = '0;
		sw = '0;
		btn = '0;
		expRead = '0;
		expErr = 1'b0;
		for (int i = 0; i < 5; i++)
			regModel[i] = '0;
		repeat (10) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);

		// Random words and strobes, each read back at once
		repeat (20)
		begin
			idx = IDX_SEG + regIndex'($urandom % 3);
			writeReg(idx, $urandom, byteStrobe'($urandom));
			readReg(idx);
		end
		writeReg(IDX_LED, $urandom, 4'hF);
		readReg(IDX_LED);

		// Steady inputs reach the read value
		swHeld = 16'($urandom);
		btnHeld = 5'($urandom);
		sw <= swHeld;
		btn <= btnHeld;
		repeat (SETTLE_CYCLES) @(posedge clk);
		apbAccess(1'b0, {IDX_SWITCH, 2'b00}, '0, '0, regWord'(swHeld), 1'b0);
		apbAccess(1'b0, {IDX_BUTTON, 2'b00}, '0, '0, regWord'(btnHeld), 1'b0);

		// One sample period glitch on a single switch
		sw <= swHeld ^ (16'h1 << ($urandom % 16));
		repeat (SAMPLE_DIV) @(posedge clk);
		sw <= swHeld;
		apbAccess(1'b0, {IDX_SWITCH, 2'b00}, '0, '0, regWord'(swHeld), 1'b0);
		repeat (SETTLE_CYCLES) @(posedge clk);
		apbAccess(1'b0, {IDX_SWITCH, 2'b00}, '0, '0, regWord'(swHeld), 1'b0);

		// Unmapped reads and writes, then writes to the input banks
		repeat (6)
		begin
			idx = 6'd5 + regIndex'($urandom % 59);
			apbAccess(1'b0, {idx, 2'b00}, '0, '0, '0, 1'b1);
			apbAccess(1'b1, {idx, 2'b00}, $urandom, 4'hF, '0, 1'b1);
		end
		apbAccess(1'b1, {IDX_SWITCH, 2'b00}, $urandom, 4'hF, '0, 1'b1);
		apbAccess(1'b1, {IDX_BUTTON, 2'b00}, $urandom, 4'hF, '0, 1'b1);
		apbAccess(1'b0, {IDX_SWITCH, 2'b00}, '0, '0, regWord'(swHeld), 1'b0);
		apbAccess(1'b0, {IDX_BUTTON, 2'b00}, '0, '0, regWord'(btnHeld), 1'b0);
		readReg(IDX_SEG);
		readReg(IDX_LED);
		readReg(IDX_SEGCTRL);

		// Scan with blink off, some digits then all digits
		writeReg(IDX_SEG, $urandom, 4'hF);
		writeReg(IDX_SEGCTRL, $urandom & 32'h0000_FFFF, 4'hF);
		repeat (4 * 8 * SCAN_DIV) @(posedge clk);
		writeReg(IDX_SEG, $urandom, 4'hF);
		writeReg(IDX_SEGCTRL, ($urandom & 32'h0000_FF00) | 32'hFF, 4'hF);
		repeat (4 * 8 * SCAN_DIV) @(posedge clk);
		@(negedge clk);

		total = dataErrors + protoErrors + scanErrors;
		$display("checks done: %0d data errors, %0d protocol errors, %0d display errors",
			dataErrors, protoErrors, scanErrors);
		if (total == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule
